//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- icache.f
rtl/icache_pkg.sv
rtl/icache_store.sv
rtl/icache_ctrl.sv
rtl/icache_perf.sv
rtl/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   clr,

    // Fetch side
    input  logic                   ifu_arvalid,
    output logic                   ifu_arready,
    input  icache_pkg::addr_t      ifu_araddr,
    input  icache_pkg::burst_len_t ifu_arlen,
    input  logic [1:0]             ifu_arburst,
    output logic                   ifu_rvalid,
    input  logic                   ifu_rready,
    output icache_pkg::word_t      ifu_rdata,
    output logic                   ifu_rlast,

    // Memory side
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    output icache_pkg::addr_t      mem_araddr,
    output icache_pkg::burst_len_t mem_arlen,
    output logic [1:0]             mem_arburst,
    input  logic                   mem_rvalid,
    output logic                   mem_rready,
    input  icache_pkg::word_t      mem_rdata,
    input  logic                   mem_rlast,

    // Store
    output icache_pkg::index_t     rd_index,
    output icache_pkg::word_sel_t  rd_word,
    input  logic                   rd_valid,
    input  icache_pkg::tag_t       rd_tag,
    input  icache_pkg::word_t      rd_data,
    output logic                   fill_en,
    output logic                   fill_tag_en,
    output icache_pkg::index_t     fill_index,
    output icache_pkg::word_sel_t  fill_word,
    output icache_pkg::tag_t       fill_tag,
    output icache_pkg::word_t      fill_data,

    // Counters
    output logic                   lookup_done,
    output logic                   lookup_hit,
    output icache_pkg::addr_t      req_addr
);

    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    addr_t       addr_q;
    word_sel_t   beat_cnt;
    addr_t       line_addr;
    logic        cacheable_in;
    logic        pass_ar;
    logic        ar_fire;
    logic        hit;
    logic        in_bypass;

    // Flash or SRAM window
    assign cacheable_in = (ifu_araddr[ADDR_WIDTH-1 -: 4] == FLASH_NIBBLE)
                       || (ifu_araddr[ADDR_WIDTH-1 -: 8] == SRAM_BYTE);
    assign pass_ar   = (state == IDLE) && !cacheable_in;
    assign in_bypass = (state == BYPASS);
    assign ar_fire   = ifu_arvalid && ifu_arready;

    // --------------------------------------------------
    // State register and request latch
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            addr_q <= ifu_araddr;
        end
    end

    // Beat position within the refill burst
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (state == REFILL_ADDR) begin
            beat_cnt <= '0;
        end else if (fill_en) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:        if (ar_fire) next_state = cacheable_in ? LOOKUP : BYPASS;
            LOOKUP:      next_state = hit ? RESPOND : REFILL_ADDR;
            REFILL_ADDR: if (mem_arready) next_state = REFILL_DATA;
            REFILL_DATA: if (mem_rvalid && mem_rlast) next_state = RESPOND;
            RESPOND:     if (ifu_rready) next_state = IDLE;
            BYPASS:      if (mem_rvalid && ifu_rready && mem_rlast) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // --------------------------------------------------
    // Lookup and refill
    // --------------------------------------------------
    assign rd_index = addr_q[OFFSET_WIDTH+WORD_SEL_WIDTH +: INDEX_WIDTH];
    assign rd_word  = addr_q[OFFSET_WIDTH +: WORD_SEL_WIDTH];
    assign hit      = rd_valid && (rd_tag == addr_q[ADDR_WIDTH-1 -: TAG_WIDTH]);

    assign line_addr = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH+WORD_SEL_WIDTH],
                        {(OFFSET_WIDTH+WORD_SEL_WIDTH){1'b0}}};

    // Memory rready is high for the whole data phase
    assign fill_en     = (state == REFILL_DATA) && mem_rvalid;
    // Tag goes in with the first beat
    assign fill_tag_en = fill_en && (beat_cnt == '0);
    assign fill_index  = rd_index;
    assign fill_word   = beat_cnt;
    assign fill_tag    = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign fill_data   = mem_rdata;

    assign lookup_done = (state == LOOKUP);
    assign lookup_hit  = hit;
    assign req_addr    = addr_q;

    // --------------------------------------------------
    // Bus multiplexing
    // --------------------------------------------------
    // Non-cacheable address phase goes straight through
    assign ifu_arready = (state == IDLE) && !clr && (cacheable_in || mem_arready);
    assign mem_arvalid = pass_ar ? (ifu_arvalid && !clr) : (state == REFILL_ADDR);
    assign mem_araddr  = pass_ar ? ifu_araddr : line_addr;
    assign mem_arlen   = pass_ar ? ifu_arlen : burst_len_t'(LINE_WORDS - 1);
    assign mem_arburst = pass_ar ? ifu_arburst :
                         (state == REFILL_ADDR) ? BURST_INCR : BURST_FIXED;

    assign mem_rready = in_bypass ? ifu_rready : (state == REFILL_DATA);
    assign ifu_rvalid = in_bypass ? mem_rvalid : (state == RESPOND);
    assign ifu_rdata  = in_bypass ? mem_rdata : rd_data;
    // Single word response from the array
    assign ifu_rlast  = in_bypass ? mem_rlast : (state == RESPOND);

endmodule

//--- rtl/icache_perf.sv
`timescale 1ns/1ps

module icache_perf (
    input  logic                clock,
    input  logic                reset,
    input  logic                lookup_done,
    input  logic                lookup_hit,
    input  icache_pkg::addr_t   req_addr,
    output icache_pkg::count_t  flash_hit,
    output icache_pkg::count_t  flash_miss,
    output icache_pkg::count_t  sram_hit,
    output icache_pkg::count_t  sram_miss
);

    import icache_pkg::*;

    logic in_flash;
    logic in_sram;

    // Region decode of the latched request
    assign in_flash = (req_addr[ADDR_WIDTH-1 -: 4] == FLASH_NIBBLE);
    assign in_sram  = (req_addr[ADDR_WIDTH-1 -: 8] == SRAM_BYTE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flash_hit  <= '0;
            flash_miss <= '0;
            sram_hit   <= '0;
            sram_miss  <= '0;
        end else if (lookup_done) begin
            if (in_flash) begin
                if (lookup_hit) begin
                    flash_hit <= flash_hit + 1'b1;
                end else begin
                    flash_miss <= flash_miss + 1'b1;
                end
            end else if (in_sram) begin
                if (lookup_hit) begin
                    sram_hit <= sram_hit + 1'b1;
                end else begin
                    sram_miss <= sram_miss + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/icache_pkg.sv
package icache_pkg;

    // --------------------------------------------------
    // Address and line geometry
    // --------------------------------------------------
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int OFFSET_WIDTH   = 2;
    localparam int WORD_SEL_WIDTH = 2;
    localparam int INDEX_WIDTH    = 3;
    localparam int LINE_WORDS     = 4;
    localparam int NUM_LINES      = 8;

    // Everything above the index is tag
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [INDEX_WIDTH-1:0]    index_t;
    typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;
    typedef logic [7:0]                burst_len_t;
    typedef logic [31:0]               count_t;

    // --------------------------------------------------
    // Region and burst encodings
    // --------------------------------------------------
    // Flash lives at 0x3xxx_xxxx
    localparam logic [3:0] FLASH_NIBBLE = 4'h3;
    // SRAM window at 0xa0xx_xxxx
    localparam logic [7:0] SRAM_BYTE    = 8'ha0;

    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] BURST_FIXED = 2'b00;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_ADDR,
        REFILL_DATA,
        RESPOND,
        BYPASS
    } ctrl_state_t;

endpackage

//--- rtl/icache_store.sv
`timescale 1ns/1ps

module icache_store (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  clr,

    // Lookup port
    input  icache_pkg::index_t    rd_index,
    input  icache_pkg::word_sel_t rd_word,
    output logic                  rd_valid,
    output icache_pkg::tag_t      rd_tag,
    output icache_pkg::word_t     rd_data,

    // Refill port
    input  logic                  fill_en,
    input  logic                  fill_tag_en,
    input  icache_pkg::index_t    fill_index,
    input  icache_pkg::word_sel_t fill_word,
    input  icache_pkg::tag_t      fill_tag,
    input  icache_pkg::word_t     fill_data
);

    import icache_pkg::*;

    logic [NUM_LINES-1:0] valid_bits;
    tag_t                 tag_mem  [0:NUM_LINES-1];
    word_t                data_mem [0:NUM_LINES-1][0:LINE_WORDS-1];

    // --------------------------------------------------
    // Valid bits
    // --------------------------------------------------
    // Flush wins over a tag write in the same cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (clr) begin
            valid_bits <= '0;
        end else if (fill_tag_en) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Tag and data arrays
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (fill_tag_en) begin
            tag_mem[fill_index] <= fill_tag;
        end
    end

    // One word per refill beat
    always_ff @(posedge clock) begin
        if (fill_en) begin
            data_mem[fill_index][fill_word] <= fill_data;
        end
    end

    // Combinational read by index and word position
    assign rd_valid = valid_bits[rd_index];
    assign rd_tag   = tag_mem[rd_index];
    assign rd_data  = data_mem[rd_index][rd_word];

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   clr,

    // Fetch side
    input  logic                   ifu_arvalid,
    output logic                   ifu_arready,
    input  icache_pkg::addr_t      ifu_araddr,
    input  icache_pkg::burst_len_t ifu_arlen,
    input  logic [1:0]             ifu_arburst,
    output logic                   ifu_rvalid,
    input  logic                   ifu_rready,
    output icache_pkg::word_t      ifu_rdata,
    output logic                   ifu_rlast,

    // Memory side
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    output icache_pkg::addr_t      mem_araddr,
    output icache_pkg::burst_len_t mem_arlen,
    output logic [1:0]             mem_arburst,
    input  logic                   mem_rvalid,
    output logic                   mem_rready,
    input  icache_pkg::word_t      mem_rdata,
    input  logic                   mem_rlast,

    // Performance counters
    output icache_pkg::count_t     flash_hit,
    output icache_pkg::count_t     flash_miss,
    output icache_pkg::count_t     sram_hit,
    output icache_pkg::count_t     sram_miss
);

    import icache_pkg::*;

    index_t    rd_index;
    word_sel_t rd_word;
    logic      rd_valid;
    tag_t      rd_tag;
    word_t     rd_data;
    logic      fill_en;
    logic      fill_tag_en;
    index_t    fill_index;
    word_sel_t fill_word;
    tag_t      fill_tag;
    word_t     fill_data;
    logic      lookup_done;
    logic      lookup_hit;
    addr_t     req_addr;

    icache_ctrl u_ctrl (.*);

    icache_store u_store (.*);

    icache_perf u_perf (.*);

endmodule

//--- tests/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts (
    input logic                   clock,
    input logic                   reset,
    input logic                   ifu_arvalid,
    input logic                   ifu_arready,
    input icache_pkg::addr_t      ifu_araddr,
    input icache_pkg::burst_len_t ifu_arlen,
    input logic [1:0]             ifu_arburst,
    input logic                   ifu_rvalid,
    input logic                   ifu_rready,
    input icache_pkg::word_t      ifu_rdata,
    input logic                   ifu_rlast,
    input logic                   mem_arvalid,
    input logic                   mem_arready,
    input icache_pkg::addr_t      mem_araddr,
    input icache_pkg::burst_len_t mem_arlen,
    input logic [1:0]             mem_arburst
);

    import icache_pkg::*;

    int   fail_count = 0;
    logic ifu_cacheable;
    logic mem_cacheable;
    logic cacheable_fire;
    logic pending;

    assign ifu_cacheable  = (ifu_araddr[31:28] == FLASH_NIBBLE)
                         || (ifu_araddr[31:24] == SRAM_BYTE);
    assign mem_cacheable  = (mem_araddr[31:28] == FLASH_NIBBLE)
                         || (mem_araddr[31:24] == SRAM_BYTE);
    assign cacheable_fire = ifu_arvalid && ifu_arready && ifu_cacheable;

    // Request accepted and its last beat not yet taken
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (ifu_arvalid && ifu_arready) begin
            pending <= 1'b1;
        end else if (ifu_rvalid && ifu_rready && ifu_rlast) begin
            pending <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Lookup timing
    // --------------------------------------------------
    // Nothing happens in the cycle of the lookup itself
    a_lookup_quiet: assert property (@(posedge clock) disable iff (reset)
        cacheable_fire |=> (!ifu_rvalid && !mem_arvalid))
        else begin
            $error("lookup cycle shows response or refill request");
            fail_count++;
        end

    // Hit answers at +2 and a miss starts its refill at +2
    a_hit_or_refill: assert property (@(posedge clock) disable iff (reset)
        $past(cacheable_fire, 2) |-> (ifu_rvalid != mem_arvalid))
        else begin
            $error("neither response nor refill two cycles after request");
            fail_count++;
        end

    // --------------------------------------------------
    // Memory-side request format
    // --------------------------------------------------
    a_refill_format: assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && mem_cacheable) |->
            (mem_araddr[3:0] == 4'h0 && mem_arlen == 8'(LINE_WORDS - 1)
             && mem_arburst == BURST_INCR))
        else begin
            $error("refill request not line aligned or wrong burst");
            fail_count++;
        end

    a_bypass_forward: assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && !mem_cacheable) |->
            (mem_araddr == ifu_araddr && mem_arlen == ifu_arlen
             && mem_arburst == ifu_arburst))
        else begin
            $error("bypass request not forwarded unchanged");
            fail_count++;
        end

    a_mem_ar_hold: assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && !mem_arready) |=>
            (mem_arvalid && $stable(mem_araddr) && $stable(mem_arlen)
             && $stable(mem_arburst)))
        else begin
            $error("memory address request dropped or changed before its handshake");
            fail_count++;
        end

    // --------------------------------------------------
    // Fetch-side read channel
    // --------------------------------------------------
    a_rdata_hold: assert property (@(posedge clock) disable iff (reset)
        (ifu_rvalid && !ifu_rready) |=>
            (ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rlast)))
        else begin
            $error("read data changed under back-pressure");
            fail_count++;
        end

    a_busy_no_accept: assert property (@(posedge clock) disable iff (reset)
        pending |-> !ifu_arready)
        else begin
            $error("address accepted while a request is in flight");
            fail_count++;
        end

endmodule

//--- tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    import icache_pkg::*;

    localparam word_t PATTERN = 32'hc3a5_5a3c;
    localparam int    TIMEOUT = 200;

    logic       clock       = 1'b0;
    logic       reset       = 1'b1;
    logic       clr         = 1'b0;
    logic       ifu_arvalid = 1'b0;
    addr_t      ifu_araddr  = '0;
    burst_len_t ifu_arlen   = '0;
    logic [1:0] ifu_arburst = 2'b00;
    logic       ifu_rready  = 1'b0;
    logic       mem_arready = 1'b0;
    logic       mem_rvalid  = 1'b0;
    word_t      mem_rdata   = '0;
    logic       mem_rlast   = 1'b0;
    logic       ifu_arready, ifu_rvalid, ifu_rlast;
    word_t      ifu_rdata;
    logic       mem_arvalid, mem_rready;
    addr_t      mem_araddr;
    burst_len_t mem_arlen;
    logic [1:0] mem_arburst;
    count_t     flash_hit, flash_miss, sram_hit, sram_miss;

    int         errors = 0;
    int         timeouts = 0;
    int         ar_count = 0;
    count_t     exp_flash_hit = 0, exp_flash_miss = 0, exp_sram_hit = 0, exp_sram_miss = 0;
    logic       line_valid [0:NUM_LINES-1];
    tag_t       line_tag [0:NUM_LINES-1];

    // Memory model state
    logic       mem_busy = 1'b0;
    logic [29:0] cur_word = '0;
    burst_len_t beats_left = '0;
    logic [1:0] cur_burst = 2'b00;

    always #2 clock = ~clock;

    icache_top UUT (.*);

    bind icache_top icache_asserts u_asserts (.*);

    function automatic word_t pattern_of(input logic [29:0] word_addr);
        return {2'b00, word_addr} ^ PATTERN;
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, UUT.u_asserts.fail_count);
        if (errors == 0 && timeouts == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        timeouts++;
    endtask

    // --------------------------------------------------
    // Memory model serving one burst at a time
    // --------------------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            mem_busy    <= 1'b0;
            mem_arready <= 1'b0;
            mem_rvalid  <= 1'b0;
        end else if (!mem_busy) begin
            if (mem_arvalid && mem_arready) begin
                mem_busy    <= 1'b1;
                mem_arready <= 1'b0;
                cur_word    <= mem_araddr[31:2];
                beats_left  <= mem_arlen;
                cur_burst   <= mem_arburst;
                ar_count    <= ar_count + 1;
            end else begin
                mem_arready <= ($urandom_range(3) != 0);
            end
        end else if (mem_rvalid && mem_rready) begin
            mem_rvalid <= 1'b0;
            if (mem_rlast) begin
                mem_busy <= 1'b0;
            end else begin
                beats_left <= beats_left - 1'b1;
                if (cur_burst == BURST_INCR) begin
                    cur_word <= cur_word + 1'b1;
                end
            end
        end else if (!mem_rvalid && $urandom_range(2) != 0) begin
            mem_rvalid <= 1'b1;
            mem_rdata  <= pattern_of(cur_word);
            mem_rlast  <= (beats_left == 0);
        end
    end

    // One fetch-side transaction and the cycles until its first rvalid
    task automatic do_fetch(input addr_t addr, input burst_len_t len, input logic [1:0] burst,
                            output int rvalid_lat);
        int          cycles;
        int          beat;
        logic        done;
        logic [29:0] exp_word;
        cycles = 0;
        beat = 0;
        done = 1'b0;
        rvalid_lat = 0;
        exp_word = addr[31:2];
        @(posedge clock);
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= addr;
        ifu_arlen   <= len;
        ifu_arburst <= burst;
        @(posedge clock);
        while (!ifu_arready && cycles < TIMEOUT) begin
            cycles++;
            @(posedge clock);
        end
        ifu_arvalid <= 1'b0;
        if (!ifu_arready) begin
            report_timeout("address handshake");
            return;
        end
        ifu_rready  <= 1'($urandom_range(1));
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clock);
            cycles++;
            if (ifu_rvalid && rvalid_lat == 0) rvalid_lat = cycles;
            if (ifu_rvalid && ifu_rready) begin
                if (ifu_rdata !== pattern_of(exp_word)) begin
                    $display("[ERROR] ifu_rdata addr %h beat %0d got %h expected %h",
                             addr, beat, ifu_rdata, pattern_of(exp_word));
                    errors++;
                end
                if (burst == BURST_INCR) exp_word = exp_word + 1'b1;
                if (ifu_rlast) done = 1'b1;
                beat++;
            end
            ifu_rready <= done ? 1'b0 : 1'($urandom_range(1));
        end
        if (!done) begin
            report_timeout("read data");
        end
    endtask

    // Fetch with expectations from the direct-mapped rules
    task automatic access(input addr_t addr, input burst_len_t len, input logic [1:0] burst);
        logic   is_flash;
        logic   is_sram;
        logic   hit;
        index_t idx;
        int     ar_before;
        int     lat;
        if (timeouts != 0) return;
        is_flash = (addr[31:28] == FLASH_NIBBLE);
        is_sram  = (addr[31:24] == SRAM_BYTE);
        idx = addr[6:4];
        hit = (is_flash || is_sram) && line_valid[idx] && (line_tag[idx] == addr[31:7]);
        ar_before = ar_count;
        do_fetch(addr, len, burst, lat);
        if (timeouts != 0) return;
        if (is_flash || is_sram) begin
            if (is_flash && hit) exp_flash_hit++;
            if (is_flash && !hit) exp_flash_miss++;
            if (is_sram && hit) exp_sram_hit++;
            if (is_sram && !hit) exp_sram_miss++;
            line_valid[idx] = 1'b1;
            line_tag[idx] = addr[31:7];
        end
        if ((ar_count - ar_before) != (hit ? 0 : 1)) begin
            $display("[ERROR] mem address handshakes addr %h got %h expected %h",
                     addr, ar_count - ar_before, hit ? 0 : 1);
            errors++;
        end
        if (hit && lat != 2) begin
            $display("[ERROR] hit latency addr %h got %h expected %h", addr, lat, 2);
            errors++;
        end
    endtask

    task automatic flush();
        @(posedge clock);
        clr <= 1'b1;
        @(posedge clock);
        clr <= 1'b0;
        for (int i = 0; i < NUM_LINES; i++) line_valid[i] = 1'b0;
    endtask

    task automatic check_count(input string name, input count_t got, input count_t expected);
        if (got !== expected) begin
            $display("[ERROR] %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    initial begin
        addr_t a;
        void'($urandom(32'h5d3d));
        for (int i = 0; i < NUM_LINES; i++) line_valid[i] = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // Directed miss, hits in the same line, bypass and flush
        access(32'h3000_0040, 8'd0, BURST_INCR);
        access(32'h3000_0040, 8'd0, BURST_INCR);
        access(32'h3000_0048, 8'd0, BURST_INCR);
        access(32'ha000_0014, 8'd0, BURST_INCR);
        access(32'h1000_0100, 8'd3, BURST_INCR);
        access(32'h1000_0200, 8'd2, BURST_FIXED);
        flush();
        access(32'h3000_0040, 8'd0, BURST_INCR);

        // Random mix over three regions
        for (int n = 0; n < 80; n++) begin
            if (n == 40) flush();
            case ($urandom_range(2))
                0: access(32'h3000_0000 | ($urandom & 32'h0000_01fc), 8'd0, BURST_INCR);
                1: access(32'ha000_0000 | ($urandom & 32'h0000_00fc), 8'd0, BURST_INCR);
                default: begin
                    a = 32'h2000_0000 | ($urandom & 32'h0000_fffc);
                    access(a, 8'($urandom_range(3)), 2'($urandom_range(1)));
                end
            endcase
        end

        @(posedge clock);
        check_count("flash_hit", flash_hit, exp_flash_hit);
        check_count("flash_miss", flash_miss, exp_flash_miss);
        check_count("sram_hit", sram_hit, exp_sram_hit);
        check_count("sram_miss", sram_miss, exp_sram_miss);
        finish_run();
    end

endmodule
